/* design/ulpb_pkg.sv */
/*
 * Ring bus control node definitions
 * Protocol constants, the watchdog count type and the bus state encoding
 * shared by the controller, its monitors and the testbench
 */
package ulpb_pkg;

	// Watchdog limit and active-phase counter width
	localparam int WATCHDOG_WIDTH = 20;

	// Cycles to wait after the data line is pulled low
	localparam int START_CYCLES = 10;

	// Interrupt hold length before the wake pattern is accepted
	localparam int INTERRUPT_CYCLES = 6;

	// EOM first, inverted ACK second
	localparam logic [1:0] CONTROL_SEQ = 2'b11;

	localparam int START_CNT_WIDTH = $clog2(START_CYCLES);
	localparam int HOLD_CNT_WIDTH = $clog2(INTERRUPT_CYCLES);

	typedef logic [WATCHDOG_WIDTH-1:0] wd_count_t;

	typedef enum logic [3:0] {
		BUS_IDLE         = 4'd0,
		BUS_ARBITRATE    = 4'd1,
		BUS_PRIO         = 4'd2,
		BUS_WAIT_START   = 4'd3,
		BUS_START        = 4'd4,
		BUS_ACTIVE       = 4'd5,
		BUS_SWITCH_ROLE  = 4'd6,
		BUS_INTERRUPT    = 4'd7,
		BUS_CONTROL0     = 4'd8,
		BUS_CONTROL1     = 4'd9,
		BUS_BACK_TO_IDLE = 4'd10
	} bus_state_t;

endpackage

/* design/ulpb_mon_if.sv */
/*
 * Bus monitor interface
 * Carries the bus state from the controller to the watchdog and the wake
 * detector, and their result levels back to the controller
 */
`timescale 1ns/1ps

interface ulpb_mon_if;
	import ulpb_pkg::*;

	bus_state_t state;
	logic wd_expired;	// Active phase must end
	logic wd_at_limit;	// Count reached the programmed threshold
	logic wake_ready;	// Hold done and wake pattern seen

	modport ctrl (
		output state,
		input  wd_expired,
		input  wd_at_limit,
		input  wake_ready
	);

	modport wd (
		input  state,
		output wd_expired,
		output wd_at_limit
	);

	modport wake (
		input  state,
		output wake_ready
	);

endinterface

/* design/ulpb_watchdog.sv */
/*
 * Active-phase watchdog
 * Counts cycles of the active phase against the programmed threshold and
 * samples the ring clock input, which ends the phase early when high
 */
`timescale 1ns/1ps

module ulpb_watchdog (
	input  logic               CLK_EXT,
	input  logic               RESETn,
	input  logic               clk_in,
	input  ulpb_pkg::wd_count_t threshold,
	ulpb_mon_if.wd             mon
);
	import ulpb_pkg::*;

	wd_count_t count;
	logic clkin_sampled;
	logic expired;

	assign expired = !(count < threshold) || clkin_sampled;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clkin_sampled <= 1'b0;
			count <= '0;
		end
		else
		begin
			clkin_sampled <= clk_in;
			if (mon.state == BUS_IDLE)
				count <= '0;
			else if (mon.state == BUS_ACTIVE && !expired)
				count <= count + 1'b1;
		end
	end

	assign mon.wd_expired = expired;
	assign mon.wd_at_limit = (count == threshold);	// Drives the forced EOM in control0

	// The controller must leave active before the count can pass the limit
	a_count_in_range: assert property (
		@(posedge CLK_EXT) disable iff (!RESETn)
		mon.state == BUS_ACTIVE |-> count <= threshold
	);

endmodule

/* design/ulpb_wake_detect.sv */
/*
 * Wake pattern detector
 * Samples the data line on both clock edges during the interrupt phase and
 * holds off acceptance until the interrupt hold counter has run out.
 * The wake pattern is three highs on falling edges, three lows on rising
 */
`timescale 1ns/1ps

module ulpb_wake_detect (
	input  logic       CLK_EXT,
	input  logic       RESETn,
	input  logic       din,
	ulpb_mon_if.wake   mon
);
	import ulpb_pkg::*;

	logic [2:0] din_sampled_neg;
	logic [2:0] din_sampled_pos;
	logic [HOLD_CNT_WIDTH-1:0] hold_cnt;

	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
			din_sampled_neg <= 3'b000;
		else if (mon.state == BUS_INTERRUPT)
			din_sampled_neg <= {din_sampled_neg[1:0], din};
	end

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
			din_sampled_pos <= 3'b000;
		else if (mon.state == BUS_INTERRUPT)
			din_sampled_pos <= {din_sampled_pos[1:0], din};
	end

	// Hold counter, rearmed whenever the bus is outside the interrupt phase
	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
			hold_cnt <= HOLD_CNT_WIDTH'(INTERRUPT_CYCLES - 1);
		else if (mon.state != BUS_INTERRUPT)
			hold_cnt <= HOLD_CNT_WIDTH'(INTERRUPT_CYCLES - 1);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign mon.wake_ready = (hold_cnt == '0) &&
		(din_sampled_neg == 3'b111) && (din_sampled_pos == 3'b000);

endmodule

/* design/ulpb_bus_ctrl.sv */
/*
 * Ring bus controller
 * Steps through one bus transaction from the start request to the control
 * bits, gates the clock onto the ring and selects what goes out on the
 * data line from a falling-edge copy of the state
 */
`timescale 1ns/1ps

module ulpb_bus_ctrl (
	input  logic       CLK_EXT,
	input  logic       RESETn,
	input  logic       din,
	output logic       clk_out,
	output logic       dout,
	ulpb_mon_if.ctrl   mon
);
	import ulpb_pkg::*;

	bus_state_t state, next_state;
	bus_state_t state_neg;
	logic [START_CNT_WIDTH-1:0] start_cnt, next_start_cnt;
	logic clk_en, next_clk_en;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			state <= BUS_IDLE;
			start_cnt <= START_CNT_WIDTH'(START_CYCLES - 1);
			clk_en <= 1'b0;
		end
		else
		begin
			state <= next_state;
			start_cnt <= next_start_cnt;
			clk_en <= next_clk_en;
		end
	end

	always_comb
	begin
		next_state = state;
		next_start_cnt = start_cnt;
		next_clk_en = clk_en;

		case (state)
			BUS_IDLE:
			begin
				if (!din)
					next_state = BUS_WAIT_START;	// A node requests the bus
				next_start_cnt = START_CNT_WIDTH'(START_CYCLES - 1);
			end

			BUS_WAIT_START:
			begin
				if (start_cnt != '0)
					next_start_cnt = start_cnt - 1'b1;
				else
				begin
					next_state = BUS_START;
					next_clk_en = 1'b1;
				end
			end

			BUS_START:
				next_state = BUS_ARBITRATE;

			BUS_ARBITRATE:
				next_state = BUS_PRIO;

			BUS_PRIO:
				next_state = BUS_ACTIVE;

			BUS_ACTIVE:
			begin
				if (mon.wd_expired)
				begin
					next_state = BUS_INTERRUPT;
					next_clk_en = 1'b0;
				end
			end

			BUS_INTERRUPT:
			begin
				if (mon.wake_ready)
				begin
					next_state = BUS_SWITCH_ROLE;
					next_clk_en = 1'b1;
				end
			end

			BUS_SWITCH_ROLE:
				next_state = BUS_CONTROL0;

			BUS_CONTROL0:
				next_state = BUS_CONTROL1;

			BUS_CONTROL1:
				next_state = BUS_BACK_TO_IDLE;

			BUS_BACK_TO_IDLE:
			begin
				next_clk_en = 1'b0;
				if (!din)
				begin
					// Line already low, so only a short start wait
					next_state = BUS_WAIT_START;
					next_start_cnt = START_CNT_WIDTH'(1);
				end
				else
					next_state = BUS_IDLE;
			end

			default:
				next_state = BUS_IDLE;
		endcase
	end

	assign clk_out = clk_en ? CLK_EXT : 1'b1;	// Ring clock parks high
	assign mon.state = state;

	// Data output changes half a cycle after the state
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
			state_neg <= BUS_IDLE;
		else
			state_neg <= state;
	end

	always_comb
	begin
		dout = din;
		case (state_neg)
			BUS_IDLE, BUS_WAIT_START, BUS_START, BUS_BACK_TO_IDLE:
				dout = 1'b1;
			BUS_INTERRUPT:
				dout = CLK_EXT;	// Own clock drives the data line
			BUS_CONTROL0:
				if (mon.wd_at_limit)
					dout = ~CONTROL_SEQ[1];
			default:
				dout = din;
		endcase
	end

	a_idle_clock_off: assert property (
		@(posedge CLK_EXT) disable iff (!RESETn)
		state == BUS_IDLE |-> !clk_en
	);

	// Interrupt is held until the wake detector reports the pattern
	a_interrupt_exit: assert property (
		@(posedge CLK_EXT) disable iff (!RESETn)
		(state == BUS_INTERRUPT && !mon.wake_ready) |=> state == BUS_INTERRUPT
	);

endmodule

/* design/ulpb_ctrl_top.sv */
/*
 * Ring bus control node top level
 * Connects the bus controller with its watchdog and wake detector
 * through the monitor interface
 */
`timescale 1ns/1ps

module ulpb_ctrl_top (
	input  logic                CLK_EXT,
	input  logic                RESETn,
	input  logic                clk_in,
	input  logic                din,
	input  ulpb_pkg::wd_count_t threshold,
	output logic                clk_out,
	output logic                dout
);

	ulpb_mon_if mon ();

	ulpb_watchdog i_watchdog (
		.CLK_EXT   (CLK_EXT),
		.RESETn    (RESETn),
		.clk_in    (clk_in),
		.threshold (threshold),
		.mon       (mon.wd)
	);

	ulpb_wake_detect i_wake_detect (
		.CLK_EXT (CLK_EXT),
		.RESETn  (RESETn),
		.din     (din),
		.mon     (mon.wake)
	);

	ulpb_bus_ctrl i_bus_ctrl (
		.CLK_EXT (CLK_EXT),
		.RESETn  (RESETn),
		.din     (din),
		.clk_out (clk_out),
		.dout    (dout),
		.mon     (mon.ctrl)
	);

endmodule

/* dv/ulpb_ctrl_tb.sv */
/*
 * Ring bus control node testbench
 * Runs two bus transactions, one ended by the watchdog limit and one by
 * the ring clock input, and checks the gated clock and the data output
 * with concurrent assertions against the expected bus timing
 */
`timescale 1ns/1ps

module ulpb_ctrl_tb;
	import ulpb_pkg::*;

	localparam int TEST_CYCLES = 60;
	localparam int MAX_CYCLES = 6 * TEST_CYCLES + 240;

	// What dout must show at the next rising edge
	localparam int MODE_HIGH = 0;
	localparam int MODE_PASS = 1;
	localparam int MODE_CLK = 2;
	localparam int MODE_EOM = 3;

	logic CLK_EXT;
	logic RESETn;
	logic clk_in;
	logic din;
	wd_count_t threshold;
	logic clk_out;
	logic dout;

	logic exp_park;	// Clock parked high in the low half before the next edge
	int dout_mode;
	integer seed;
	int errors;
	int errors_at_start;
	int pass_count;
	int fail_count;
	int cycles;
	string test_name;

	ulpb_ctrl_top i_dut (
		.CLK_EXT   (CLK_EXT),
		.RESETn    (RESETn),
		.clk_in    (clk_in),
		.din       (din),
		.threshold (threshold),
		.clk_out   (clk_out),
		.dout      (dout)
	);

	always #20 CLK_EXT = ~CLK_EXT;

	always @(posedge CLK_EXT)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string what, input logic expected, input logic actual);
		errors++;
		$display("Mismatch in %s on %s: expected %b, actual %b",
			test_name, what, expected, actual);
	endtask

	// Sampled just before the edge, a running clock_out is low
	a_clk_gate: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		clk_out == exp_park)
		else report_mismatch("clk_out", exp_park, $sampled(clk_out));

	a_dout_high: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		dout_mode == MODE_HIGH |-> dout)
		else report_mismatch("dout", 1'b1, $sampled(dout));

	a_dout_pass: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		dout_mode == MODE_PASS |-> dout == din)
		else report_mismatch("dout", $sampled(din), $sampled(dout));

	a_dout_eom: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		dout_mode == MODE_EOM |-> dout == ~CONTROL_SEQ[1])
		else report_mismatch("dout", ~CONTROL_SEQ[1], $sampled(dout));

	a_dout_clk_low: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		dout_mode == MODE_CLK |-> dout == CLK_EXT)
		else report_mismatch("dout", $sampled(CLK_EXT), $sampled(dout));

	a_dout_clk_high: assert property (@(negedge CLK_EXT) disable iff (!RESETn)
		dout_mode == MODE_CLK |-> dout == CLK_EXT)
		else report_mismatch("dout", $sampled(CLK_EXT), $sampled(dout));

	task automatic step();
		@(posedge CLK_EXT);
		#2;
	endtask

	task automatic close_test();
		if (errors == errors_at_start)
		begin
			pass_count++;
			$display("Test %s: ok", test_name);
		end
		else
		begin
			fail_count++;
			$display("Test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic begin_test(input string name);
		if (test_name != "")
			close_test();
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic drive_random_din();
		int rnd;
		rnd = $random(seed);
		din = rnd[0];
	endtask

	// Entered just after the edge that moved the bus into wait_start
	task automatic start_phase(input int wait_edges);
		repeat (wait_edges)
			step();
		exp_park = 1'b0;	// Start sets the clock enable
		step();
		dout_mode = MODE_PASS;	// Arbitrate passes the line through
		drive_random_din();
		step();
		drive_random_din();
		step();
		drive_random_din();	// Now in active
	endtask

	task automatic active_until_limit(input int thr);
		repeat (thr + 1)
		begin
			step();
			drive_random_din();
		end
	endtask

	task automatic active_until_clk_in();
		repeat (2)
		begin
			step();
			drive_random_din();
		end
		clk_in = 1'b1;
		repeat (2)
			step();	// Sampled at the first edge, the phase ends at the second
		clk_in = 1'b0;
	endtask

	// Ring answers with the wake pattern after pre_cycles quiet cycles
	task automatic interrupt_phase(input int pre_cycles);
		int n;
		int exp_n;
		logic restarted;
		n = 0;
		restarted = 1'b0;
		// Three pattern cycles, then one edge that sees wake_ready
		exp_n = (pre_cycles + 4 > INTERRUPT_CYCLES) ? pre_cycles + 4 : INTERRUPT_CYCLES;
		exp_park = 1'b1;
		dout_mode = MODE_CLK;
		while (!restarted)
		begin
			din = 1'b1;	// High at the falling edge
			@(negedge CLK_EXT);
			#1;
			if (clk_out == 1'b0)
				restarted = 1'b1;
			else
			begin
				#1;
				if (n >= pre_cycles)
					din = 1'b0;	// Low at the rising edge
				step();
				n++;
			end
		end
		exp_park = 1'b0;	// Switch role with the clock running again
		dout_mode = MODE_PASS;
		a_wake_time: assert (n == exp_n)
		else
		begin
			errors++;
			$display("Mismatch in %s on interrupt length: expected %0d, actual %0d",
				test_name, exp_n, n);
		end
	endtask

	task automatic control_bits(input logic at_limit, input logic next_din);
		step();
		dout_mode = at_limit ? MODE_EOM : MODE_PASS;	// Control0
		step();
		dout_mode = MODE_PASS;
		din = next_din;	// Seen by back_to_idle
	endtask

	task automatic back_to_idle();
		step();
		dout_mode = MODE_HIGH;
		step();
		exp_park = 1'b1;	// Enable drops on the edge that leaves back_to_idle
	endtask

	initial
	begin
		int unsigned thr;
		CLK_EXT = 1'b0;
		RESETn = 1'b0;
		clk_in = 1'b0;
		din = 1'b1;
		threshold = wd_count_t'(10);
		exp_park = 1'b1;
		dout_mode = MODE_HIGH;
		seed = 32'hd6f4;
		errors = 0;
		errors_at_start = 0;
		pass_count = 0;
		fail_count = 0;
		cycles = 0;
		test_name = "";
		repeat (3)
			@(posedge CLK_EXT);
		#2;
		RESETn = 1'b1;

		begin_test("idle_after_reset");
		repeat (10)
			step();

		begin_test("start_delay");
		thr = 3 + ($unsigned($random(seed)) % 8);
		threshold = wd_count_t'(thr);
		din = 1'b0;	// A node pulls the line low
		step();
		start_phase(START_CYCLES);
		begin_test("watchdog_limit");
		active_until_limit(thr);
		begin_test("interrupt_hold");
		interrupt_phase(0);
		begin_test("control_eom");
		control_bits(1'b1, 1'b0);
		threshold = wd_count_t'(20);
		begin_test("return_short_start");
		back_to_idle();
		start_phase(2);

		begin_test("watchdog_clk_in");
		active_until_clk_in();
		begin_test("interrupt_late_wake");
		interrupt_phase(4);
		begin_test("control_pass");
		control_bits(1'b0, 1'b1);
		begin_test("return_idle");
		back_to_idle();
		repeat (5)
			step();
		close_test();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sources.f */
design/ulpb_pkg.sv
design/ulpb_mon_if.sv
design/ulpb_watchdog.sv
design/ulpb_wake_detect.sv
design/ulpb_bus_ctrl.sv
design/ulpb_ctrl_top.sv
dv/ulpb_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ring bus control node testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module ulpb_ctrl_tb \
	--Mdir "$BUILD_DIR" \
	-o ulpb_ctrl_sim

"./$BUILD_DIR/ulpb_ctrl_sim" | tee "$LOG"

if grep -q "TESTBENCH PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
